//--- logic/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// array geometry and datapath widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CONV_COLS     4   // weight columns
`define CONV_ROWS     4   // pixel rows
`define CONV_X_BITS   8
`define CONV_K_BITS   8
`define CONV_Y_BITS   24  // sums wrap at this width

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timing and flow control
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CONV_LAT_MUL  3   // multiplier register stages
`define CONV_CREDITS  4   // results the consumer can absorb
`define CONV_TAPS_MAX 16
`define CONV_TAP_BITS 5   // must hold CONV_TAPS_MAX

`endif

//--- logic/conv_ctrl_pkg.sv
`include "conv_config.svh"

package conv_ctrl_pkg;

  typedef enum logic {
    IDLE = 1'b0,  // waiting for a configuration beat
    RUN  = 1'b1   // taking data beats of one group
  } engine_state_e;

  // taps per output group, 1 to CONV_TAPS_MAX
  typedef logic [`CONV_TAP_BITS-1:0] taps_t;

  // credit count, zero up to CONV_CREDITS inclusive
  typedef logic [$clog2(`CONV_CREDITS+1)-1:0] credit_t;

endpackage

//--- logic/conv_data_pkg.sv
`include "conv_config.svh"

package conv_data_pkg;

  // one input pixel
  typedef logic signed [`CONV_X_BITS-1:0] pixel_t;

  // one kernel weight
  typedef logic signed [`CONV_K_BITS-1:0] weight_t;

  // full precision product of a pixel and a weight
  typedef logic signed [`CONV_X_BITS+`CONV_K_BITS-1:0] product_t;

  // accumulated sum, wraps modulo 2^Y_BITS
  typedef logic signed [`CONV_Y_BITS-1:0] sum_t;

endpackage

//--- logic/conv_top.sv
`include "conv_config.svh"

module conv_top (
  input  logic                                                clk,
  input  logic                                                resetn,
  input  logic                                                i_cfg_valid,
  input  conv_ctrl_pkg::taps_t                                i_cfg_taps,
  output logic                                                o_cfg_ready,
  input  logic                                                i_s_valid,
  input  logic                                                i_s_last,
  input  conv_data_pkg::pixel_t  [`CONV_ROWS-1:0]             i_s_pixels,
  input  conv_data_pkg::weight_t [`CONV_COLS-1:0]             i_s_weights,
  output logic                                                o_s_ready,
  output logic                                                o_m_valid,
  output logic                                                o_m_last,
  output conv_data_pkg::sum_t [`CONV_COLS-1:0][`CONV_ROWS-1:0] o_m_data,
  input  logic                                                i_m_credit
);

  logic                                                en;
  logic                                                load;
  logic                                                accept;
  logic                                                tap_first;
  logic                                                tap_last;
  logic                                                res_valid;
  logic                                                res_last;
  conv_data_pkg::sum_t [`CONV_COLS-1:0][`CONV_ROWS-1:0] res_data;

  engine_fsm u_engine_fsm (
    .clk         (clk),
    .resetn      (resetn),
    .i_en        (en),
    .i_cfg_valid (i_cfg_valid),
    .o_cfg_ready (o_cfg_ready),
    .i_s_valid   (i_s_valid),
    .i_tap_last  (tap_last),
    .o_s_ready   (o_s_ready),
    .o_load      (load),
    .o_accept    (accept)
  );

  tap_counter u_tap_counter (
    .clk      (clk),
    .resetn   (resetn),
    .i_load   (load),
    .i_taps   (i_cfg_taps),
    .i_accept (accept),
    .o_first  (tap_first),
    .o_last   (tap_last)
  );

  proc_engine u_proc_engine (
    .clk          (clk),
    .resetn       (resetn),
    .i_en         (en),
    .i_accept     (accept),
    .i_first      (tap_first),
    .i_last       (tap_last),
    .i_frame_last (i_s_last),
    .i_pixels     (i_s_pixels),
    .i_weights    (i_s_weights),
    .o_res_valid  (res_valid),
    .o_res_last   (res_last),
    .o_res_data   (res_data)
  );

  credit_out_stage u_credit_out_stage (
    .clk        (clk),
    .resetn     (resetn),
    .i_valid    (res_valid),
    .i_last     (res_last),
    .i_data     (res_data),
    .o_en       (en),
    .o_m_valid  (o_m_valid),
    .o_m_last   (o_m_last),
    .o_m_data   (o_m_data),
    .i_m_credit (i_m_credit)
  );

endmodule

//--- logic/credit_out_stage.sv
`include "conv_config.svh"

module credit_out_stage (
  input  logic                                                clk,
  input  logic                                                resetn,
  input  logic                                                i_valid,
  input  logic                                                i_last,
  input  conv_data_pkg::sum_t [`CONV_COLS-1:0][`CONV_ROWS-1:0] i_data,
  output logic                                                o_en,
  output logic                                                o_m_valid,
  output logic                                                o_m_last,
  output conv_data_pkg::sum_t [`CONV_COLS-1:0][`CONV_ROWS-1:0] o_m_data,
  input  logic                                                i_m_credit
);

  localparam int COLS = `CONV_COLS;
  localparam int ROWS = `CONV_ROWS;

  conv_data_pkg::sum_t [COLS-1:0][ROWS-1:0] data_q [2];
  logic [1:0]                              last_q;
  logic                                    wr_ptr_q;
  logic                                    rd_ptr_q;
  logic [1:0]                              count_q;  // entries held, 0 to 2
  conv_ctrl_pkg::credit_t                  credit_q;
  logic                                    push;
  logic                                    pop;

  assign o_en = (count_q != 2'd2);  // a full buffer freezes the whole pipeline
  assign push = i_valid & o_en;
  assign pop  = o_m_valid;          // the consumer takes every result we send

  always_ff @(posedge clk) begin
    if (push) begin
      data_q[wr_ptr_q] <= i_data;
      last_q[wr_ptr_q] <= i_last;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop) rd_ptr_q <= ~rd_ptr_q;
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // credits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!resetn) begin
      credit_q <= conv_ctrl_pkg::credit_t'(`CONV_CREDITS);
    end else begin
      credit_q <= credit_q + conv_ctrl_pkg::credit_t'(i_m_credit)
                           - conv_ctrl_pkg::credit_t'(pop);
    end
  end

  assign o_m_valid = (count_q != '0) && (credit_q != '0);
  assign o_m_last  = last_q[rd_ptr_q];
  assign o_m_data  = data_q[rd_ptr_q];

endmodule

//--- logic/engine_fsm.sv
module engine_fsm (
  input  logic clk,
  input  logic resetn,
  input  logic i_en,
  input  logic i_cfg_valid,
  output logic o_cfg_ready,
  input  logic i_s_valid,
  input  logic i_tap_last,
  output logic o_s_ready,
  output logic o_load,
  output logic o_accept
);

  conv_ctrl_pkg::engine_state_e state_q;
  conv_ctrl_pkg::engine_state_e state_next;
  logic                         cfg_ready_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    state_next = state_q;
    case (state_q)
      conv_ctrl_pkg::IDLE: begin
        if (o_load) begin
          state_next = conv_ctrl_pkg::RUN;
        end
      end
      conv_ctrl_pkg::RUN: begin
        if (o_accept && i_tap_last) begin
          state_next = conv_ctrl_pkg::IDLE;  // group fully taken, earlier results may still be in flight
        end
      end
      default: state_next = conv_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q     <= conv_ctrl_pkg::IDLE;
      cfg_ready_q <= 1'b0;
    end else begin
      state_q     <= state_next;
      cfg_ready_q <= (state_next == conv_ctrl_pkg::IDLE);  // low out of reset, high one cycle later
    end
  end

  assign o_cfg_ready = cfg_ready_q;
  assign o_load      = i_cfg_valid & cfg_ready_q;

  // a frozen pipeline cannot take a beat
  assign o_s_ready = (state_q == conv_ctrl_pkg::RUN) & i_en;
  assign o_accept  = o_s_ready & i_s_valid;

endmodule

//--- logic/proc_element.sv
`include "conv_config.svh"

module proc_element (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   i_en,
  input  conv_data_pkg::pixel_t  i_pixel,
  input  conv_data_pkg::weight_t i_weight,
  input  logic                   i_first,
  output conv_data_pkg::sum_t    o_sum
);

  localparam int LAT_MUL = `CONV_LAT_MUL;

  conv_data_pkg::product_t mul_q [LAT_MUL];
  logic [LAT_MUL-1:0]      first_q;  // first flag aligned with the product chain
  conv_data_pkg::sum_t     acc_q;

  always_ff @(posedge clk) begin
    if (i_en) begin
      mul_q[0] <= i_pixel * i_weight;  // both operands signed so the product is signed
      for (int i = 1; i < LAT_MUL; i++) begin
        mul_q[i] <= mul_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      first_q <= '0;
    end else if (i_en) begin
      first_q <= (first_q << 1) | LAT_MUL'(i_first);
    end
  end

  // the first product of a group replaces the old sum instead of adding to it
  always_ff @(posedge clk) begin
    if (i_en) begin
      if (first_q[LAT_MUL-1]) begin
        acc_q <= conv_data_pkg::sum_t'(mul_q[LAT_MUL-1]);
      end else begin
        acc_q <= acc_q + conv_data_pkg::sum_t'(mul_q[LAT_MUL-1]);
      end
    end
  end

  assign o_sum = acc_q;

endmodule

//--- logic/proc_engine.sv
`include "conv_config.svh"

module proc_engine (
  input  logic                                        clk,
  input  logic                                        resetn,
  input  logic                                        i_en,
  input  logic                                        i_accept,
  input  logic                                        i_first,
  input  logic                                        i_last,
  input  logic                                        i_frame_last,
  input  conv_data_pkg::pixel_t  [`CONV_ROWS-1:0]     i_pixels,
  input  conv_data_pkg::weight_t [`CONV_COLS-1:0]     i_weights,
  output logic                                        o_res_valid,
  output logic                                        o_res_last,
  output conv_data_pkg::sum_t [`CONV_COLS-1:0][`CONV_ROWS-1:0] o_res_data
);

  localparam int COLS    = `CONV_COLS;
  localparam int ROWS    = `CONV_ROWS;
  localparam int LAT_MUL = `CONV_LAT_MUL;
  localparam int LAT_CTL = LAT_MUL + 1;  // multiplier stages plus the accumulator

  conv_data_pkg::pixel_t [ROWS-1:0] pix_gated;
  logic                             first_gated;

  // control bits {accept, last, frame_last} walking beside the products
  logic [2:0] ctl_q [LAT_CTL];
  logic       acc_d;
  logic       last_d;
  logic       frame_last_d;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bubble gating
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // a zero pixel makes every product of an idle cycle zero, so it adds nothing
  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      pix_gated[r] = i_accept ? i_pixels[r] : '0;
    end
  end

  assign first_gated = i_first & i_accept;  // only a taken beat may restart the sums

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // element array
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar c = 0; c < COLS; c++) begin : g_col
    for (genvar r = 0; r < ROWS; r++) begin : g_row
      proc_element u_pe (
        .clk      (clk),
        .resetn   (resetn),
        .i_en     (i_en),
        .i_pixel  (pix_gated[r]),
        .i_weight (i_weights[c]),
        .i_first  (first_gated),
        .o_sum    (o_res_data[c][r])
      );
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // control delay line
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < LAT_CTL; i++) begin
        ctl_q[i] <= '0;
      end
    end else if (i_en) begin
      ctl_q[0] <= {i_accept, i_last, i_frame_last};
      for (int i = 1; i < LAT_CTL; i++) begin
        ctl_q[i] <= ctl_q[i-1];
      end
    end
  end

  assign {acc_d, last_d, frame_last_d} = ctl_q[LAT_CTL-1];

  // high in the cycle after the last product of a group was accumulated
  assign o_res_valid = acc_d & last_d;
  assign o_res_last  = frame_last_d;  // only read together with o_res_valid

endmodule

//--- logic/tap_counter.sv
module tap_counter (
  input  logic                clk,
  input  logic                resetn,
  input  logic                i_load,
  input  conv_ctrl_pkg::taps_t i_taps,
  input  logic                i_accept,
  output logic                o_first,
  output logic                o_last
);

  conv_ctrl_pkg::taps_t taps_q;  // taps in the current group
  conv_ctrl_pkg::taps_t pos_q;   // index of the next beat within the group

  always_ff @(posedge clk) begin
    if (!resetn) begin
      taps_q <= '0;
      pos_q  <= '0;
    end else if (i_load) begin
      taps_q <= i_taps;
      pos_q  <= '0;
    end else if (i_accept) begin
      if (o_last) begin
        pos_q <= '0;  // wrap so the next group starts at its first beat
      end else begin
        pos_q <= pos_q + 1'b1;
      end
    end
  end

  assign o_first = (pos_q == '0);
  assign o_last  = (pos_q == conv_ctrl_pkg::taps_t'(taps_q - 1'b1));

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the convolution testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module conv_tb \
  --Mdir "$build_dir" \
  -o conv_sim \
  -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

"./$build_dir/conv_sim"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished cleanly"
exit 0

//--- tb/conv_props.sv
`include "conv_config.svh"

module conv_props (
  input logic                          clk,
  input logic                          resetn,
  input logic                          i_m_valid,
  input logic                          i_m_credit,
  input conv_ctrl_pkg::credit_t        i_credit,
  input logic                          i_cfg_ready,
  input logic                          i_s_ready,
  input conv_ctrl_pkg::engine_state_e  i_state
);

  int avail_q;  // credits granted by the consumer and not yet spent, seen at the ports

  always_ff @(posedge clk) begin
    if (!resetn) begin
      avail_q <= `CONV_CREDITS;
    end else begin
      avail_q <= avail_q + int'(i_m_credit) - int'(i_m_valid);
    end
  end

  a_valid_needs_credit: assert property (@(posedge clk) disable iff (!resetn)
    i_m_valid |-> (avail_q > 0)) else $error("result sent with no credit left");

  a_credit_bound: assert property (@(posedge clk) disable iff (!resetn)
    i_credit <= `CONV_CREDITS) else $error("credit count above its reset value");

  a_ready_exclusive: assert property (@(posedge clk) disable iff (!resetn)
    !(i_cfg_ready && i_s_ready)) else $error("config and data ready at once");

  // the first sampled cycle after reset shows every output low, the FSM idle and credits full
  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(resetn) |-> (!i_m_valid && !i_cfg_ready && !i_s_ready &&
                       i_state == conv_ctrl_pkg::IDLE && i_credit == `CONV_CREDITS))
    else $error("outputs active in the first cycle after reset");

endmodule

bind credit_out_stage conv_props u_out_props (
  .clk         (clk),
  .resetn      (resetn),
  .i_m_valid   (o_m_valid),
  .i_m_credit  (i_m_credit),
  .i_credit    (credit_q),
  .i_cfg_ready (1'b0),
  .i_s_ready   (1'b0),
  .i_state     (conv_ctrl_pkg::IDLE)
);

bind engine_fsm conv_props u_fsm_props (
  .clk         (clk),
  .resetn      (resetn),
  .i_m_valid   (1'b0),
  .i_m_credit  (1'b0),
  .i_credit    (conv_ctrl_pkg::credit_t'(`CONV_CREDITS)),
  .i_cfg_ready (o_cfg_ready),
  .i_s_ready   (o_s_ready),
  .i_state     (state_q)
);

//--- tb/conv_tb.sv
`include "conv_config.svh"

module conv_tb;

  localparam int          COLS       = `CONV_COLS;
  localparam int          ROWS       = `CONV_ROWS;
  localparam int          LATENCY    = `CONV_LAT_MUL + 2;  // multiplier, accumulator, buffer
  localparam int          NUM_GROUPS = 23;
  localparam logic [31:0] LFSR_SEED  = 32'h848c_c9a0;

  typedef conv_data_pkg::sum_t [COLS-1:0][ROWS-1:0] result_t;

  typedef struct packed {
    int          taps;
    bit          frame;    // frame-last flag carried by the group's last beat
    logic [15:0] gaps;     // bit b set puts one idle cycle before beat b
    int          delay;    // cycles before the consumer returns the credit
    bit          extreme;  // only the most negative and most positive values
    bit          lat;      // result latency is checked for this group
  } group_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus table
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam group_t GROUPS [NUM_GROUPS] = '{
    '{1,  1'b0, 16'h0000, 0,  1'b0, 1'b1},
    '{1,  1'b1, 16'h0000, 0,  1'b0, 1'b1},
    '{1,  1'b0, 16'h0001, 0,  1'b0, 1'b1},
    '{2,  1'b0, 16'h0000, 0,  1'b0, 1'b1},
    '{3,  1'b0, 16'h0000, 1,  1'b0, 1'b0},
    '{5,  1'b1, 16'h0000, 0,  1'b0, 1'b0},
    '{8,  1'b0, 16'h0000, 2,  1'b0, 1'b0},
    '{16, 1'b1, 16'h0000, 0,  1'b0, 1'b0},
    '{6,  1'b0, 16'h0014, 0,  1'b0, 1'b0},
    '{4,  1'b0, 16'h000e, 1,  1'b0, 1'b0},
    '{16, 1'b1, 16'h8421, 0,  1'b0, 1'b0},
    '{1,  1'b0, 16'h0000, 40, 1'b0, 1'b0},  // slow credits from here on fill the buffer
    '{1,  1'b1, 16'h0000, 40, 1'b0, 1'b0},
    '{2,  1'b0, 16'h0000, 40, 1'b0, 1'b0},
    '{1,  1'b0, 16'h0000, 40, 1'b0, 1'b0},
    '{1,  1'b1, 16'h0000, 40, 1'b0, 1'b0},
    '{2,  1'b0, 16'h0002, 40, 1'b0, 1'b0},
    '{1,  1'b0, 16'h0000, 40, 1'b0, 1'b0},
    '{1,  1'b1, 16'h0000, 40, 1'b0, 1'b0},
    '{16, 1'b0, 16'h0000, 3,  1'b1, 1'b0},
    '{7,  1'b1, 16'h0040, 0,  1'b1, 1'b0},
    '{1,  1'b1, 16'h0000, 0,  1'b1, 1'b0},
    '{3,  1'b0, 16'h0000, 5,  1'b0, 1'b0}
  };

  logic                                    clk;
  logic                                    resetn;
  logic                                    i_cfg_valid;
  conv_ctrl_pkg::taps_t                    i_cfg_taps;
  logic                                    o_cfg_ready;
  logic                                    i_s_valid;
  logic                                    i_s_last;
  conv_data_pkg::pixel_t  [ROWS-1:0]       i_s_pixels;
  conv_data_pkg::weight_t [COLS-1:0]       i_s_weights;
  logic                                    o_s_ready;
  logic                                    o_m_valid;
  logic                                    o_m_last;
  result_t                                 o_m_data;
  logic                                    i_m_credit;

  logic [31:0] lfsr_state;
  int          cycle = 0;
  result_t     exp_data_q [$];
  bit          exp_last_q [$];
  int          exp_delay_q [$];
  int          exp_cyc_q [$];
  bit          exp_lat_q [$];
  int          credit_due_q [$];
  int          sent_count = 0;
  int          returned_count = 0;
  int          stall_cycles = 0;

  conv_top u_conv_top (
    .clk         (clk),
    .resetn      (resetn),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_taps  (i_cfg_taps),
    .o_cfg_ready (o_cfg_ready),
    .i_s_valid   (i_s_valid),
    .i_s_last    (i_s_last),
    .i_s_pixels  (i_s_pixels),
    .i_s_weights (i_s_weights),
    .o_s_ready   (o_s_ready),
    .o_m_valid   (o_m_valid),
    .o_m_last    (o_m_last),
    .o_m_data    (o_m_data),
    .i_m_credit  (i_m_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic end_with_failure();
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random values and compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // most negative or most positive two's complement value of a given width
  function automatic logic [31:0] edge_value(input bit neg, input int width);
    return neg ? (32'hffff_ffff << (width - 1)) : ((32'h1 << (width - 1)) - 1);
  endfunction

  task automatic check_sum(input string name, input conv_data_pkg::sum_t got,
                           input conv_data_pkg::sum_t want);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
      end_with_failure();
    end
  endtask

  task automatic check_last(input string name, input bit got, input bit want);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %0b, expected %0b", $time, name, got, want);
      end_with_failure();
    end
  endtask

  task automatic check_latency(input string name, input int got, input int want);
    if (got != want) begin
      $display("Mismatch at %0t: %s is %0d cycles, expected %0d", $time, name, got, want);
      end_with_failure();
    end
  endtask

  task automatic check_credit(input string name, input conv_ctrl_pkg::credit_t got,
                              input conv_ctrl_pkg::credit_t want);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, want);
      end_with_failure();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // driver with reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_group(input group_t g);
    int                                acc [COLS][ROWS];
    result_t                           want;
    logic [31:0]                       bits;
    conv_data_pkg::pixel_t  [ROWS-1:0] pix;
    conv_data_pkg::weight_t [COLS-1:0] wgt;
    int                                accept_cyc;
    for (int c = 0; c < COLS; c++) begin
      for (int r = 0; r < ROWS; r++) acc[c][r] = 0;
    end
    i_cfg_valid = 1'b1;
    i_cfg_taps  = conv_ctrl_pkg::taps_t'(g.taps);
    @(negedge clk);
    while (!o_cfg_ready) begin
      @(posedge clk);
      #1;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    i_cfg_valid = 1'b0;
    for (int b = 0; b < g.taps; b++) begin
      if (g.gaps[b]) begin
        i_s_valid  = 1'b0;
        i_s_pixels = ~i_s_pixels;  // noise on an idle bus must not reach the sums
        @(posedge clk);
        #1;
      end
      for (int r = 0; r < ROWS; r++) begin
        bits   = g.extreme ? edge_value(rand_bits(1), `CONV_X_BITS) : rand_bits(`CONV_X_BITS);
        pix[r] = conv_data_pkg::pixel_t'(bits);
      end
      for (int c = 0; c < COLS; c++) begin
        bits   = g.extreme ? edge_value(rand_bits(1), `CONV_K_BITS) : rand_bits(`CONV_K_BITS);
        wgt[c] = conv_data_pkg::weight_t'(bits);
      end
      i_s_valid   = 1'b1;
      i_s_pixels  = pix;
      i_s_weights = wgt;
      i_s_last    = (b == g.taps - 1) ? g.frame : 1'b0;
      @(negedge clk);
      while (!o_s_ready) begin  // held while the pipeline is frozen
        @(posedge clk);
        #1;
        @(negedge clk);
      end
      accept_cyc = cycle;
      for (int c = 0; c < COLS; c++) begin
        for (int r = 0; r < ROWS; r++) acc[c][r] += int'(pix[r]) * int'(wgt[c]);
      end
      @(posedge clk);
      #1;
    end
    i_s_valid = 1'b0;
    i_s_last  = 1'b0;
    for (int c = 0; c < COLS; c++) begin
      for (int r = 0; r < ROWS; r++) want[c][r] = conv_data_pkg::sum_t'(acc[c][r]);
    end
    exp_data_q.push_back(want);
    exp_last_q.push_back(g.frame);
    exp_delay_q.push_back(g.delay);
    exp_cyc_q.push_back(accept_cyc);
    exp_lat_q.push_back(g.lat);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // result monitor and consumer credits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(negedge clk) begin : monitor
    result_t want;
    if (resetn && !u_conv_top.en) begin
      stall_cycles++;
      if (o_s_ready) begin
        $display("Data ready stayed high at %0t while the pipeline was frozen", $time);
        end_with_failure();
      end
    end
    if (resetn && o_m_valid) begin
      if (exp_data_q.size() == 0) begin
        $display("A result arrived at %0t while no group was waiting for one", $time);
        end_with_failure();
      end else begin
        want = exp_data_q.pop_front();
        for (int c = 0; c < COLS; c++) begin
          for (int r = 0; r < ROWS; r++) begin
            check_sum($sformatf("o_m_data[%0d][%0d]", c, r), o_m_data[c][r], want[c][r]);
          end
        end
        check_last("o_m_last", o_m_last, exp_last_q.pop_front());
        if (exp_lat_q.pop_front()) begin
          check_latency("o_m_valid latency", cycle - exp_cyc_q[0], LATENCY);
        end
        void'(exp_cyc_q.pop_front());
        credit_due_q.push_back(cycle + exp_delay_q.pop_front());
        sent_count++;
        // a pulse still on the wire has not reached the DUT yet
        if (sent_count - returned_count + int'(i_m_credit) > `CONV_CREDITS) begin
          $display("More than %0d results outstanding at %0t", `CONV_CREDITS, $time);
          end_with_failure();
        end
      end
    end
  end

  initial begin : credit_return
    int idx;
    i_m_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      idx = -1;
      for (int i = 0; i < credit_due_q.size(); i++) begin
        if (idx < 0 && credit_due_q[i] <= cycle) idx = i;
      end
      if (idx >= 0) begin  // one pulse per cycle, late ones queue up
        credit_due_q.delete(idx);
        returned_count++;
        i_m_credit = 1'b1;
      end else begin
        i_m_credit = 1'b0;
      end
    end
  end

  initial begin : watchdog
    longint beats;
    longint limit;
    beats = 0;
    for (int n = 0; n < NUM_GROUPS; n++) beats += GROUPS[n].taps;
    limit = (beats + NUM_GROUPS * 20) * 8 * 4;
    #(limit);
    $display("Timeout after %0d time units with %0d results received", limit, sent_count);
    end_with_failure();
  end

  initial begin : stimulus
    resetn      = 1'b0;
    i_cfg_valid = 1'b0;
    i_cfg_taps  = '0;
    i_s_valid   = 1'b0;
    i_s_last    = 1'b0;
    i_s_pixels  = '0;
    i_s_weights = '0;
    lfsr_state  = LFSR_SEED;
    repeat (5) @(posedge clk);
    #1;
    resetn = 1'b1;
    @(posedge clk);
    #1;
    for (int n = 0; n < NUM_GROUPS; n++) run_group(GROUPS[n]);
    while (exp_data_q.size() != 0 || credit_due_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    #1;
    check_credit("credit_q", u_conv_top.u_credit_out_stage.credit_q,
                 conv_ctrl_pkg::credit_t'(`CONV_CREDITS));
    if (stall_cycles == 0) begin
      $display("Credit back-pressure never froze the pipeline");
      end_with_failure();
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+logic
logic/conv_data_pkg.sv
logic/conv_ctrl_pkg.sv
logic/proc_element.sv
logic/proc_engine.sv
logic/tap_counter.sv
logic/engine_fsm.sv
logic/credit_out_stage.sv
logic/conv_top.sv
tb/conv_props.sv
tb/conv_tb.sv
